//--- logic/vpu_pkg.sv
package vpu_pkg;

    localparam int ELEM_WIDTH     = 16;
    localparam int LANES          = 4;
    localparam int VEC_WIDTH      = LANES * ELEM_WIDTH;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int MEM_ADDR_WIDTH = 12;
    localparam int PC_WIDTH       = 8;

    typedef enum logic [4:0] {
        OP_NOP   = 5'd0,
        OP_ALU   = 5'd1,
        OP_LOAD  = 5'd2,
        OP_STORE = 5'd3
    } opcode_e;

    // codes 6 and 7 give zero
    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_OR   = 3'd3,
        ALU_XOR  = 3'd4,
        ALU_MINU = 3'd5
    } alu_funct_e;

    typedef struct packed {
        opcode_e                   opcode;
        logic [REG_ADDR_WIDTH-1:0] vd;
        logic [REG_ADDR_WIDTH-1:0] vs1;
        logic [REG_ADDR_WIDTH-1:0] vs2;
        alu_funct_e                funct;
        logic [8:0]                unused;
    } alu_fmt_t;

    typedef struct packed {
        opcode_e                   opcode;
        logic [REG_ADDR_WIDTH-1:0] vd;
        logic [REG_ADDR_WIDTH-1:0] vs;
        logic [MEM_ADDR_WIDTH-1:0] addr;
        logic [4:0]                unused;
    } mem_fmt_t;

    // opcode sits in bits 31:27 in both formats
    typedef union packed {
        alu_fmt_t alu;
        mem_fmt_t mem;
    } instr_word_u;

endpackage

//--- logic/vpu_ifs.sv
`timescale 1ns/1ps

// decoded instruction and operands, decode to execute
interface id_ex_if;
    vpu_pkg::opcode_e                         opcode;
    vpu_pkg::alu_funct_e                      funct;
    logic [vpu_pkg::REG_ADDR_WIDTH-1:0]       vd;
    logic [vpu_pkg::REG_ADDR_WIDTH-1:0]       vs1;
    logic [vpu_pkg::REG_ADDR_WIDTH-1:0]       vs2;
    logic [vpu_pkg::MEM_ADDR_WIDTH-1:0]       addr;
    logic [vpu_pkg::VEC_WIDTH-1:0]            op1;
    logic [vpu_pkg::VEC_WIDTH-1:0]            op2;
    logic                                     valid;

    modport producer (
        output opcode, funct, vd, vs1, vs2, addr, op1, op2, valid
    );

    modport consumer (
        input opcode, funct, vd, vs1, vs2, addr, op1, op2, valid
    );
endinterface

// register-writing result of one pipeline stage
interface stage_res_if;
    logic                               reg_we;
    logic [vpu_pkg::REG_ADDR_WIDTH-1:0] vd;
    logic [vpu_pkg::VEC_WIDTH-1:0]      data;

    modport producer (output reg_we, vd, data);
    modport consumer (input reg_we, vd, data);
    // forwarding and register file write
    modport observer (input reg_we, vd, data);
endinterface

//--- logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               advance,
    input  logic [31:0]                        instr,
    output logic [vpu_pkg::PC_WIDTH-1:0]       pc,
    output logic [vpu_pkg::REG_ADDR_WIDTH-1:0] rd_addr1,
    output logic [vpu_pkg::REG_ADDR_WIDTH-1:0] rd_addr2,
    input  logic [vpu_pkg::VEC_WIDTH-1:0]      rd_data1,
    input  logic [vpu_pkg::VEC_WIDTH-1:0]      rd_data2,
    id_ex_if.producer                          id_ex
);

    vpu_pkg::instr_word_u iw;
    vpu_pkg::opcode_e     opcode;

    assign iw     = instr;
    assign opcode = iw.alu.opcode;

    // register read addresses by format
    always_comb begin
        rd_addr1 = '0;
        rd_addr2 = '0;
        case (opcode)
            vpu_pkg::OP_ALU: begin
                rd_addr1 = iw.alu.vs1;
                rd_addr2 = iw.alu.vs2;
            end
            // store data comes through port 2
            vpu_pkg::OP_STORE: rd_addr2 = iw.mem.vs;
            default: ;
        endcase
    end

    // fetch counter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (advance) begin
            pc <= pc + 1'b1;
        end
    end

    //============================================================
    // decode / execute register
    //============================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_ex.valid  <= 1'b0;
            id_ex.opcode <= vpu_pkg::OP_NOP;
        end else if (advance) begin
            id_ex.valid  <= (opcode != vpu_pkg::OP_NOP);
            id_ex.opcode <= opcode;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            id_ex.funct <= iw.alu.funct;
            id_ex.vd    <= iw.alu.vd;
            id_ex.vs1   <= rd_addr1;
            id_ex.vs2   <= rd_addr2;
            id_ex.addr  <= iw.mem.addr;
            id_ex.op1   <= rd_data1;
            id_ex.op2   <= rd_data2;
        end
    end

endmodule

//--- logic/vector_regfile.sv
`timescale 1ns/1ps

module vector_regfile #(
    parameter int REG_DEPTH = 32
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [vpu_pkg::REG_ADDR_WIDTH-1:0] rd_addr1,
    input  logic [vpu_pkg::REG_ADDR_WIDTH-1:0] rd_addr2,
    output logic [vpu_pkg::VEC_WIDTH-1:0]      rd_data1,
    output logic [vpu_pkg::VEC_WIDTH-1:0]      rd_data2,
    stage_res_if.observer                      wr,
    input  logic                               wr_en
);

    logic [vpu_pkg::VEC_WIDTH-1:0] regs [REG_DEPTH];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && int'(wr.vd) < REG_DEPTH) begin
            regs[wr.vd] <= wr.data;
        end
    end

    // write-through so decode sees the result retiring this cycle
    assign rd_data1 = (wr_en && wr.vd == rd_addr1) ? wr.data :
                      (int'(rd_addr1) < REG_DEPTH) ? regs[rd_addr1] : '0;
    assign rd_data2 = (wr_en && wr.vd == rd_addr2) ? wr.data :
                      (int'(rd_addr2) < REG_DEPTH) ? regs[rd_addr2] : '0;

endmodule

//--- logic/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               advance,
    id_ex_if.consumer                          id_ex,
    stage_res_if.producer                      mem_res,
    stage_res_if.observer                      wb_res,
    input  logic [vpu_pkg::VEC_WIDTH-1:0]      mem_rdata,
    output logic [vpu_pkg::MEM_ADDR_WIDTH-1:0] mem_addr,
    output logic                               mem_ren,
    output logic                               mem_we,
    output logic [vpu_pkg::VEC_WIDTH-1:0]      mem_wdata
);

    localparam int EW = vpu_pkg::ELEM_WIDTH;

    logic [vpu_pkg::VEC_WIDTH-1:0]      op_a;
    logic [vpu_pkg::VEC_WIDTH-1:0]      op_b;
    logic [vpu_pkg::VEC_WIDTH-1:0]      alu_out;
    vpu_pkg::opcode_e                   mem_op;
    logic [vpu_pkg::REG_ADDR_WIDTH-1:0] mem_vd;
    logic [vpu_pkg::VEC_WIDTH-1:0]      mem_alu;
    logic                               mem_reg_we;
    logic [vpu_pkg::VEC_WIDTH-1:0]      mem_data;
    logic                               load_hold_vld;
    logic [vpu_pkg::VEC_WIDTH-1:0]      load_hold;

    //============================================================
    // operand forwarding
    //============================================================

    // memory stage first, then writeback, then the decode read
    always_comb begin
        op_a = id_ex.op1;
        if (mem_reg_we && mem_vd == id_ex.vs1) begin
            op_a = mem_data;
        end else if (wb_res.reg_we && wb_res.vd == id_ex.vs1) begin
            op_a = wb_res.data;
        end
        op_b = id_ex.op2;
        if (mem_reg_we && mem_vd == id_ex.vs2) begin
            op_b = mem_data;
        end else if (wb_res.reg_we && wb_res.vd == id_ex.vs2) begin
            op_b = wb_res.data;
        end
    end

    // lane ALU, all ops wrap per lane
    always_comb begin
        logic [EW-1:0] a;
        logic [EW-1:0] b;
        logic [EW-1:0] r;
        alu_out = '0;
        for (int i = 0; i < vpu_pkg::LANES; i++) begin
            a = op_a[i*EW +: EW];
            b = op_b[i*EW +: EW];
            case (id_ex.funct)
                vpu_pkg::ALU_ADD:  r = a + b;
                vpu_pkg::ALU_SUB:  r = a - b;
                vpu_pkg::ALU_AND:  r = a & b;
                vpu_pkg::ALU_OR:   r = a | b;
                vpu_pkg::ALU_XOR:  r = a ^ b;
                vpu_pkg::ALU_MINU: r = (a < b) ? a : b;
                default:           r = '0;
            endcase
            alu_out[i*EW +: EW] = r;
        end
    end

    // memory request, a store writes only on the advancing edge
    assign mem_addr  = id_ex.addr;
    assign mem_ren   = id_ex.valid && id_ex.opcode == vpu_pkg::OP_LOAD;
    assign mem_we    = id_ex.valid && id_ex.opcode == vpu_pkg::OP_STORE && advance;
    assign mem_wdata = op_b;

    //============================================================
    // execute / memory register
    //============================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_op <= vpu_pkg::OP_NOP;
        end else if (advance) begin
            if (id_ex.valid) begin
                mem_op <= id_ex.opcode;
            end else begin
                mem_op <= vpu_pkg::OP_NOP;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            mem_vd  <= id_ex.vd;
            mem_alu <= alu_out;
        end
    end

    // keep load data while frozen, the next load may re-read the port
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            load_hold_vld <= 1'b0;
        end else if (advance) begin
            load_hold_vld <= 1'b0;
        end else if (mem_op == vpu_pkg::OP_LOAD) begin
            load_hold_vld <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!advance && !load_hold_vld) begin
            load_hold <= mem_rdata;
        end
    end

    assign mem_reg_we = (mem_op == vpu_pkg::OP_ALU) || (mem_op == vpu_pkg::OP_LOAD);
    assign mem_data   = (mem_op != vpu_pkg::OP_LOAD) ? mem_alu :
                        load_hold_vld ? load_hold : mem_rdata;

    assign mem_res.reg_we = mem_reg_we;
    assign mem_res.vd     = mem_vd;
    assign mem_res.data   = mem_data;

endmodule

//--- logic/writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage #(
    parameter int RESULT_CREDITS = 4
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               en,
    input  logic                               credit_return,
    stage_res_if.consumer                      mem_res,
    stage_res_if.producer                      wb_res,
    output logic                               advance,
    output logic                               wr_en,
    output logic                               data_out_vld,
    output logic [vpu_pkg::VEC_WIDTH-1:0]      data_out,
    output logic [vpu_pkg::REG_ADDR_WIDTH-1:0] reg_wb
);

    localparam int CW = $clog2(RESULT_CREDITS + 1);

    logic                               wb_reg_we;
    logic [vpu_pkg::REG_ADDR_WIDTH-1:0] wb_vd;
    logic [vpu_pkg::VEC_WIDTH-1:0]      wb_data;
    logic [CW-1:0]                      credit_cnt;
    logic                               fire;

    // a waiting result with no credit freezes everything
    assign fire    = en && wb_reg_we && credit_cnt != '0;
    assign advance = en && !(wb_reg_we && credit_cnt == '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_reg_we <= 1'b0;
        end else if (advance) begin
            wb_reg_we <= mem_res.reg_we;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            wb_vd   <= mem_res.vd;
            wb_data <= mem_res.data;
        end
    end

    //============================================================
    // result credits
    //============================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit_cnt <= CW'(RESULT_CREDITS);
        end else if (fire && !credit_return) begin
            credit_cnt <= credit_cnt - 1'b1;
        end else if (!fire && credit_return && credit_cnt != CW'(RESULT_CREDITS)) begin
            credit_cnt <= credit_cnt + 1'b1;
        end
    end

    assign wr_en        = fire;
    assign data_out_vld = fire;
    assign data_out     = wb_data;
    assign reg_wb       = wb_vd;

    assign wb_res.reg_we = wb_reg_we;
    assign wb_res.vd     = wb_vd;
    assign wb_res.data   = wb_data;

endmodule

//--- logic/vpu_top.sv
`timescale 1ns/1ps

module vpu_top #(
    parameter int RESULT_CREDITS = 4,
    parameter int REG_DEPTH      = 32
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               en,
    input  logic [31:0]                        instr,
    output logic [vpu_pkg::PC_WIDTH-1:0]       pc,
    output logic [vpu_pkg::MEM_ADDR_WIDTH-1:0] mem_addr,
    output logic                               mem_ren,
    output logic                               mem_we,
    output logic [vpu_pkg::VEC_WIDTH-1:0]      mem_wdata,
    input  logic [vpu_pkg::VEC_WIDTH-1:0]      mem_rdata,
    input  logic                               credit_return,
    output logic                               data_out_vld,
    output logic [vpu_pkg::VEC_WIDTH-1:0]      data_out,
    output logic [vpu_pkg::REG_ADDR_WIDTH-1:0] reg_wb
);

    logic                               advance;
    logic                               wr_en;
    logic [vpu_pkg::REG_ADDR_WIDTH-1:0] rd_addr1;
    logic [vpu_pkg::REG_ADDR_WIDTH-1:0] rd_addr2;
    logic [vpu_pkg::VEC_WIDTH-1:0]      rd_data1;
    logic [vpu_pkg::VEC_WIDTH-1:0]      rd_data2;

    id_ex_if     id_ex ();
    stage_res_if mem_res ();
    stage_res_if wb_res ();

    //============================================================
    // decode and register read
    //============================================================

    decode_stage decode_stage_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .advance  (advance),
        .instr    (instr),
        .pc       (pc),
        .rd_addr1 (rd_addr1),
        .rd_addr2 (rd_addr2),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2),
        .id_ex    (id_ex.producer)
    );

    vector_regfile #(
        .REG_DEPTH (REG_DEPTH)
    ) vector_regfile_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_addr1 (rd_addr1),
        .rd_addr2 (rd_addr2),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2),
        .wr       (wb_res.observer),
        .wr_en    (wr_en)
    );

    //============================================================
    // execute, memory and writeback
    //============================================================

    execute_stage execute_stage_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .advance   (advance),
        .id_ex     (id_ex.consumer),
        .mem_res   (mem_res.producer),
        .wb_res    (wb_res.observer),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_ren   (mem_ren),
        .mem_we    (mem_we),
        .mem_wdata (mem_wdata)
    );

    writeback_stage #(
        .RESULT_CREDITS (RESULT_CREDITS)
    ) writeback_stage_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .en            (en),
        .credit_return (credit_return),
        .mem_res       (mem_res.consumer),
        .wb_res        (wb_res.producer),
        .advance       (advance),
        .wr_en         (wr_en),
        .data_out_vld  (data_out_vld),
        .data_out      (data_out),
        .reg_wb        (reg_wb)
    );

endmodule

//--- bench/vpu_checker.sv
`timescale 1ns/1ps

// properties on the result credits and the memory port of vpu_top
module vpu_checker #(
    parameter int RESULT_CREDITS = 4
) (
    input logic                                clk,
    input logic                                rst_n,
    input logic                                en,
    input logic                                mem_ren,
    input logic                                mem_we,
    input logic                                data_out_vld,
    input logic [$clog2(RESULT_CREDITS+1)-1:0] credit_cnt
);

    // read by the testbench at the end of the run
    int fail_count = 0;

    a_credit_bound: assert property (
        @(posedge clk) disable iff (!rst_n) credit_cnt <= RESULT_CREDITS
    ) else begin
        fail_count++;
        $error("credit count %0d above limit %0d", credit_cnt, RESULT_CREDITS);
    end

    a_quiet_when_off: assert property (
        @(posedge clk) disable iff (!rst_n) !en |-> !data_out_vld
    ) else begin
        fail_count++;
        $error("data_out_vld high while en is low");
    end

    a_ren_we_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(mem_ren && mem_we)
    ) else begin
        fail_count++;
        $error("mem_ren and mem_we high together");
    end

endmodule

bind vpu_top vpu_checker #(
    .RESULT_CREDITS (RESULT_CREDITS)
) vpu_checker_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .en           (en),
    .mem_ren      (mem_ren),
    .mem_we       (mem_we),
    .data_out_vld (data_out_vld),
    .credit_cnt   (writeback_stage_inst.credit_cnt)
);

//--- bench/vpu_tb.sv
`timescale 1ns/1ps

module vpu_tb;

    localparam int CREDITS   = 4;
    localparam int RET_DELAY = 3;
    // instructions over all five tests
    localparam int TOTAL_INSTR     = 52;
    localparam int WATCHDOG_CYCLES = TOTAL_INSTR * 20 + 500;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        en;
    logic [31:0] instr;
    logic [7:0]  pc;
    logic [11:0] mem_addr;
    logic        mem_ren;
    logic        mem_we;
    logic [63:0] mem_wdata;
    logic [63:0] mem_rdata = '0;
    logic        credit_return = 1'b0;
    logic        data_out_vld;
    logic [63:0] data_out;
    logic [4:0]  reg_wb;

    logic [31:0] imem [256];
    logic [63:0] dmem [4096];
    logic [63:0] ref_mem [4096];
    logic [63:0] ref_regs [32];
    int          prog_len;

    // expected results and stores for the monitor
    logic [4:0]  exp_vd [512];
    logic [63:0] exp_data [512];
    int          exp_wr = 0;
    int          exp_rd = 0;
    logic [11:0] st_addr [64];
    logic [63:0] st_data [64];
    int          st_wr = 0;
    int          st_rd = 0;

    int          test_errors = 0;
    int          mon_errors = 0;
    int          results_seen = 0;
    logic        hold_credits = 1'b0;
    logic [RET_DELAY-1:0] ret_pipe;
    int          owed;

    always #5 clk = ~clk;

    vpu_top #(
        .RESULT_CREDITS (CREDITS),
        .REG_DEPTH      (32)
    ) vpu_top_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .en            (en),
        .instr         (instr),
        .pc            (pc),
        .mem_addr      (mem_addr),
        .mem_ren       (mem_ren),
        .mem_we        (mem_we),
        .mem_wdata     (mem_wdata),
        .mem_rdata     (mem_rdata),
        .credit_return (credit_return),
        .data_out_vld  (data_out_vld),
        .data_out      (data_out),
        .reg_wb        (reg_wb)
    );

    //============================================================
    // memory models and credit return
    //============================================================

    assign instr = imem[pc];

    always @(posedge clk) begin
        if (mem_ren) begin
            mem_rdata <= dmem[mem_addr];
        end
        if (mem_we) begin
            dmem[mem_addr] <= mem_wdata;
        end
    end

    // returns one credit RET_DELAY cycles after each result unless held
    always @(posedge clk) begin
        if (!rst_n) begin
            ret_pipe      <= '0;
            owed          = 0;
            credit_return <= 1'b0;
        end else begin
            ret_pipe <= {ret_pipe[RET_DELAY-2:0], data_out_vld};
            if (ret_pipe[RET_DELAY-1]) begin
                owed = owed + 1;
            end
            if (!hold_credits && owed > 0) begin
                credit_return <= 1'b1;
                owed          = owed - 1;
            end else begin
                credit_return <= 1'b0;
            end
        end
    end

    //============================================================
    // result and store monitor
    //============================================================

    always @(negedge clk) begin
        if (rst_n) begin
            if (!en && data_out_vld) begin
                mon_errors++;
                $display("CHECK FAILED at %0t: data_out_vld expected 0, got %0b",
                         $time, data_out_vld);
            end
            if (!en && mem_we) begin
                mon_errors++;
                $display("CHECK FAILED at %0t: mem_we expected 0, got %0b",
                         $time, mem_we);
            end
            if (data_out_vld) begin
                results_seen++;
                if (exp_rd >= exp_wr) begin
                    mon_errors++;
                    $display("ERROR: unexpected result for v%0d at %0t", reg_wb, $time);
                end else begin
                    if (reg_wb !== exp_vd[exp_rd]) begin
                        mon_errors++;
                        $display("CHECK FAILED at %0t: reg_wb expected %0d, got %0d",
                                 $time, exp_vd[exp_rd], reg_wb);
                    end
                    if (data_out !== exp_data[exp_rd]) begin
                        mon_errors++;
                        $display("CHECK FAILED at %0t: data_out expected %h, got %h",
                                 $time, exp_data[exp_rd], data_out);
                    end
                    exp_rd++;
                end
            end
            if (mem_we) begin
                if (st_rd >= st_wr) begin
                    mon_errors++;
                    $display("ERROR: unexpected store to %h at %0t", mem_addr, $time);
                end else begin
                    if (mem_addr !== st_addr[st_rd]) begin
                        mon_errors++;
                        $display("CHECK FAILED at %0t: mem_addr expected %h, got %h",
                                 $time, st_addr[st_rd], mem_addr);
                    end
                    if (mem_wdata !== st_data[st_rd]) begin
                        mon_errors++;
                        $display("CHECK FAILED at %0t: mem_wdata expected %h, got %h",
                                 $time, st_data[st_rd], mem_wdata);
                    end
                    st_rd++;
                end
            end
        end
    end

    //============================================================
    // reference model and program building
    //============================================================

    // lane-wise reference with 16-bit wrap
    function automatic logic [63:0] lane_alu_model(input logic [2:0] funct,
                                                   input logic [63:0] a,
                                                   input logic [63:0] b);
        logic [63:0] r;
        logic [15:0] x;
        logic [15:0] y;
        r = '0;
        for (int i = 0; i < 4; i++) begin
            x = a[i*16 +: 16];
            y = b[i*16 +: 16];
            case (funct)
                3'd0:    r[i*16 +: 16] = x + y;
                3'd1:    r[i*16 +: 16] = x - y;
                3'd2:    r[i*16 +: 16] = x & y;
                3'd3:    r[i*16 +: 16] = x | y;
                3'd4:    r[i*16 +: 16] = x ^ y;
                3'd5:    r[i*16 +: 16] = (x < y) ? x : y;
                default: r[i*16 +: 16] = 16'h0;
            endcase
        end
        return r;
    endfunction

    function automatic logic [63:0] fill_word(input logic [11:0] a);
        return {4'h1, a, 4'h2, a, 4'h3, a, 4'h4, a};
    endfunction

    task automatic expect_result(input int vd, input logic [63:0] data);
        exp_vd[exp_wr]   = 5'(vd);
        exp_data[exp_wr] = data;
        exp_wr++;
    endtask

    task automatic set_data(input logic [11:0] addr, input logic [63:0] data);
        dmem[addr]    = data;
        ref_mem[addr] = data;
    endtask

    task automatic add_alu(input logic [2:0] funct, input int vd, vs1, vs2);
        logic [63:0] res;
        res           = lane_alu_model(funct, ref_regs[vs1], ref_regs[vs2]);
        ref_regs[vd]  = res;
        imem[prog_len] = {5'd1, 5'(vd), 5'(vs1), 5'(vs2), funct, 9'd0};
        prog_len++;
        expect_result(vd, res);
    endtask

    task automatic add_load(input int vd, input logic [11:0] addr);
        ref_regs[vd]   = ref_mem[addr];
        imem[prog_len] = {5'd2, 5'(vd), 5'd0, addr, 5'd0};
        prog_len++;
        expect_result(vd, ref_regs[vd]);
    endtask

    task automatic add_store(input int vs, input logic [11:0] addr);
        ref_mem[addr]  = ref_regs[vs];
        imem[prog_len] = {5'd3, 5'd0, 5'(vs), addr, 5'd0};
        prog_len++;
        st_addr[st_wr] = addr;
        st_data[st_wr] = ref_regs[vs];
        st_wr++;
    endtask

    task automatic add_nop();
        imem[prog_len] = 32'h0;
        prog_len++;
    endtask

    //============================================================
    // test flow
    //============================================================

    task automatic start_test(input string name);
        @(posedge clk);
        rst_n        <= 1'b0;
        en           <= 1'b0;
        hold_credits <= 1'b0;
        for (int a = 0; a < 256; a++) begin
            imem[a] = 32'h0;
        end
        for (int r = 0; r < 32; r++) begin
            ref_regs[r] = '0;
        end
        prog_len = 0;
        $display("test: %s", name);
    endtask

    task automatic run_program();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        en    <= 1'b1;
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while ((exp_rd < exp_wr || st_rd < st_wr) && n < 300) begin
            @(posedge clk);
            n++;
        end
        if (exp_rd < exp_wr || st_rd < st_wr) begin
            test_errors++;
            $display("ERROR: %0d results and %0d stores never arrived",
                     exp_wr - exp_rd, st_wr - st_rd);
        end
        // catch stray outputs after the program
        repeat (6) @(posedge clk);
    endtask

    task automatic test_lane_alu();
        start_test("lane alu");
        set_data(12'h010, {$urandom(), $urandom()});
        set_data(12'h011, {$urandom(), $urandom()});
        add_load(1, 12'h010);
        add_load(2, 12'h011);
        add_alu(vpu_pkg::ALU_ADD, 3, 1, 2);
        add_alu(vpu_pkg::ALU_SUB, 4, 1, 2);
        add_alu(vpu_pkg::ALU_AND, 5, 1, 2);
        add_alu(vpu_pkg::ALU_OR, 6, 1, 2);
        add_alu(vpu_pkg::ALU_XOR, 7, 1, 2);
        add_alu(vpu_pkg::ALU_MINU, 8, 1, 2);
        add_alu(vpu_pkg::ALU_MINU, 9, 2, 1);
        add_alu(vpu_pkg::ALU_SUB, 10, 2, 1);
        add_alu(3'd7, 11, 1, 2);
        run_program();
        wait_drained();
    endtask

    task automatic test_forwarding();
        start_test("forwarding");
        set_data(12'h020, {$urandom(), $urandom()});
        add_load(1, 12'h020);
        add_alu(vpu_pkg::ALU_ADD, 2, 1, 1);
        add_alu(vpu_pkg::ALU_ADD, 3, 2, 1);
        add_alu(vpu_pkg::ALU_SUB, 4, 3, 2);
        add_alu(vpu_pkg::ALU_XOR, 4, 4, 3);
        add_load(5, 12'h021);
        add_alu(vpu_pkg::ALU_AND, 6, 5, 4);
        add_nop();
        add_alu(vpu_pkg::ALU_OR, 7, 6, 5);
        add_nop();
        add_nop();
        add_alu(vpu_pkg::ALU_ADD, 8, 7, 1);
        run_program();
        wait_drained();
    endtask

    task automatic test_store();
        start_test("store");
        add_load(1, 12'h050);
        add_load(2, 12'h051);
        add_alu(vpu_pkg::ALU_ADD, 3, 1, 2);
        add_store(3, 12'h200);
        add_nop();
        add_load(4, 12'h200);
        add_alu(vpu_pkg::ALU_ADD, 5, 4, 3);
        add_store(5, 12'h201);
        add_load(6, 12'h201);
        run_program();
        wait_drained();
    endtask

    task automatic test_credits();
        int base;
        start_test("credits");
        hold_credits <= 1'b1;
        add_load(1, 12'h040);
        add_load(2, 12'h041);
        add_alu(vpu_pkg::ALU_ADD, 3, 1, 2);
        add_alu(vpu_pkg::ALU_SUB, 4, 3, 1);
        add_load(5, 12'h042);
        add_load(6, 12'h043);
        add_alu(vpu_pkg::ALU_XOR, 7, 5, 6);
        add_alu(vpu_pkg::ALU_OR, 8, 7, 4);
        add_store(8, 12'h400);
        add_load(9, 12'h400);
        add_alu(vpu_pkg::ALU_AND, 10, 9, 3);
        base = results_seen;
        run_program();
        repeat (40) @(posedge clk);
        if (results_seen - base != CREDITS) begin
            test_errors++;
            $display("CHECK FAILED at %0t: data_out_vld count expected %0d, got %0d",
                     $time, CREDITS, results_seen - base);
        end
        hold_credits <= 1'b0;
        wait_drained();
    endtask

    task automatic test_enable();
        logic [7:0] pc_frozen;
        start_test("enable");
        add_load(1, 12'h030);
        add_load(2, 12'h031);
        add_alu(vpu_pkg::ALU_ADD, 3, 1, 2);
        add_store(3, 12'h300);
        add_alu(vpu_pkg::ALU_XOR, 4, 3, 1);
        add_alu(vpu_pkg::ALU_SUB, 5, 4, 2);
        add_load(6, 12'h300);
        add_alu(vpu_pkg::ALU_MINU, 7, 6, 5);
        add_store(7, 12'h301);
        run_program();
        // freeze with the first store in execute and a result in writeback
        repeat (4) @(posedge clk);
        en <= 1'b0;
        @(negedge clk);
        pc_frozen = pc;
        repeat (10) @(negedge clk);
        if (pc !== pc_frozen) begin
            test_errors++;
            $display("CHECK FAILED at %0t: pc expected %0d, got %0d", $time, pc_frozen, pc);
        end
        @(posedge clk);
        en <= 1'b1;
        wait_drained();
    endtask

    initial begin
        int total;
        rst_n = 1'b0;
        en    = 1'b0;
        void'($urandom(32'hde81));
        for (int a = 0; a < 4096; a++) begin
            dmem[a]    = fill_word(12'(a));
            ref_mem[a] = fill_word(12'(a));
        end
        for (int a = 0; a < 256; a++) begin
            imem[a] = 32'h0;
        end
        test_lane_alu();
        test_forwarding();
        test_store();
        test_credits();
        test_enable();
        total = test_errors + mon_errors + vpu_top_inst.vpu_checker_inst.fail_count;
        $display("errors: %0d in tests, %0d in monitor, %0d in assertions",
                 test_errors, mon_errors, vpu_top_inst.vpu_checker_inst.fail_count);
        if (total == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * 10);
        $display("ERROR: watchdog expired at %0t before the tests finished", $time);
        $display("Something failed");
        $finish;
    end

endmodule

//--- project.f
logic/vpu_pkg.sv
logic/vpu_ifs.sv
logic/decode_stage.sv
logic/vector_regfile.sv
logic/execute_stage.sv
logic/writeback_stage.sv
logic/vpu_top.sv
bench/vpu_checker.sv
bench/vpu_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module vpu_tb -f project.f -o vpu_sim
./obj_dir/vpu_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log
grep -q "^Everything OK$" sim.log
